/* Makefile */
# Verilator build for the VC router testbench

VERILATOR ?= verilator
TOP       ?= tb_floo_vc_router
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* filelist.f */
+incdir+.
floo_flit_pkg.sv
floo_vc_pkg.sv
floo_input_port.sv
floo_sa_local.sv
floo_sa_global.sv
floo_credit_counter.sv
floo_vc_router.sv
tb_floo_vc_router.sv

/* floo_cfg.svh */
// =========================================================================
// router configuration
// sizes of the mesh router ports, virtual channels and flit fields
// =========================================================================

`ifndef FLOO_CFG_SVH
`define FLOO_CFG_SVH

// router ports N, E, S, W and local
`define FLOO_NUM_PORTS 5

// virtual channels per port, same in both directions
`define FLOO_NUM_VC 2

// buffer slots per VC, also the initial downstream credit
`define FLOO_VC_DEPTH 2

// width of one mesh coordinate
`define FLOO_COORD_W 2

// payload bits carried by every flit
`define FLOO_PAYLOAD_W 16

`endif

/* floo_credit_counter.sv */
// =========================================================================
// output credit counter
// tracks free slots per downstream VC and picks the VC for the next flit
// =========================================================================

`timescale 1ns/1ns
`include "floo_cfg.svh"

module floo_credit_counter (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                credit_v_i,
  input  floo_vc_pkg::vc_id_t credit_id_i,
  input  logic                consume_v_i,
  output logic                vc_free_o,
  output floo_vc_pkg::vc_id_t vc_sel_o
);
  import floo_vc_pkg::*;

  credit_cnt_t [`FLOO_NUM_VC-1:0] cnt_q;

  // most credits wins, lower index on a tie
  always_comb begin
    vc_id_t best;
    best = '0;
    for (int v = 1; v < `FLOO_NUM_VC; v++) begin
      if (cnt_q[v] > cnt_q[best]) begin
        best = vc_id_t'(v);
      end
    end
    vc_sel_o  = best;
    vc_free_o = (cnt_q[best] != '0);
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int v = 0; v < `FLOO_NUM_VC; v++) begin
        cnt_q[v] <= credit_cnt_t'(`FLOO_VC_DEPTH);
      end
    end else begin
      for (int v = 0; v < `FLOO_NUM_VC; v++) begin
        // return and consume on the same VC cancel out
        if (credit_v_i && (credit_id_i == vc_id_t'(v))) begin
          if (!(consume_v_i && (vc_sel_o == vc_id_t'(v)))) begin
            cnt_q[v] <= cnt_q[v] + 1'b1;
          end
        end else if (consume_v_i && (vc_sel_o == vc_id_t'(v))) begin
          cnt_q[v] <= cnt_q[v] - 1'b1;
        end
      end
    end
  end

  for (genvar v = 0; v < `FLOO_NUM_VC; v++) begin : gen_cnt_check
    a_cnt_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      cnt_q[v] <= credit_cnt_t'(`FLOO_VC_DEPTH));
  end

  a_no_empty_consume: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    consume_v_i |-> vc_free_o);

endmodule

/* floo_flit_pkg.sv */
// =========================================================================
// flit format package
// flit field layout, coordinates and output directions of the router
// =========================================================================

`include "floo_cfg.svh"

package floo_flit_pkg;

  // output directions, also the port index order of the router
  typedef enum logic [2:0] {
    dir_north = 3'd0,
    dir_east  = 3'd1,
    dir_south = 3'd2,
    dir_west  = 3'd3,
    dir_local = 3'd4
  } route_dir_e;

  typedef logic [`FLOO_COORD_W-1:0] coord_t;

  // =========================================================================
  // field layout, from msb down: dst x, dst y, vc id, payload
  // =========================================================================
  localparam int flit_vc_w       = $clog2(`FLOO_NUM_VC);
  localparam int flit_payload_lsb = 0;
  localparam int flit_vc_lsb     = flit_payload_lsb + `FLOO_PAYLOAD_W;
  localparam int flit_dst_y_lsb  = flit_vc_lsb + flit_vc_w;
  localparam int flit_dst_x_lsb  = flit_dst_y_lsb + `FLOO_COORD_W;
  localparam int flit_w          = flit_dst_x_lsb + `FLOO_COORD_W;

  typedef logic [flit_w-1:0] flit_t;

endpackage

/* floo_input_port.sv */
// =========================================================================
// router input port
// per-VC flit buffers, XY route of each head flit and credit return
// =========================================================================

`timescale 1ns/1ns
`include "floo_cfg.svh"

module floo_input_port (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  input  logic                                              data_v_i,
  input  floo_flit_pkg::flit_t                              data_i,
  input  floo_flit_pkg::coord_t                             xy_id_x_i,
  input  floo_flit_pkg::coord_t                             xy_id_y_i,
  input  logic                                              pop_v_i,
  input  floo_vc_pkg::vc_mask_t                             pop_vc_oh_i,
  output floo_vc_pkg::vc_mask_t                             head_v_o,
  output floo_flit_pkg::flit_t [`FLOO_NUM_VC-1:0]           head_flit_o,
  output floo_vc_pkg::port_mask_t [`FLOO_NUM_VC-1:0]        head_dir_oh_o,
  output logic                                              credit_v_o,
  output floo_vc_pkg::vc_id_t                               credit_id_o
);
  import floo_flit_pkg::*;
  import floo_vc_pkg::*;

  localparam int ptr_w = (`FLOO_VC_DEPTH > 1) ? $clog2(`FLOO_VC_DEPTH) : 1;
  typedef logic [ptr_w-1:0] ptr_t;

  flit_t                          mem_q [`FLOO_NUM_VC][`FLOO_VC_DEPTH];
  ptr_t [`FLOO_NUM_VC-1:0]        wr_ptr_q;
  ptr_t [`FLOO_NUM_VC-1:0]        rd_ptr_q;
  credit_cnt_t [`FLOO_NUM_VC-1:0] count_q;
  vc_id_t                         wr_vc;
  vc_id_t                         pop_id;
  vc_mask_t                       wr_en;
  vc_mask_t                       rd_en;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(`FLOO_VC_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // x first, then y, local when both match
  function automatic port_mask_t xy_route(input flit_t flit, input coord_t x, input coord_t y);
    coord_t     dst_x;
    coord_t     dst_y;
    port_mask_t dir_oh;
    dst_x  = flit[flit_dst_x_lsb +: `FLOO_COORD_W];
    dst_y  = flit[flit_dst_y_lsb +: `FLOO_COORD_W];
    dir_oh = '0;
    if (dst_x > x) begin
      dir_oh[dir_east] = 1'b1;
    end else if (dst_x < x) begin
      dir_oh[dir_west] = 1'b1;
    end else if (dst_y > y) begin
      dir_oh[dir_south] = 1'b1;
    end else if (dst_y < y) begin
      dir_oh[dir_north] = 1'b1;
    end else begin
      dir_oh[dir_local] = 1'b1;
    end
    return dir_oh;
  endfunction

  assign wr_vc = data_i[flit_vc_lsb +: flit_vc_w];

  always_comb begin
    pop_id = '0;
    for (int v = 0; v < `FLOO_NUM_VC; v++) begin
      wr_en[v]         = data_v_i && (wr_vc == vc_id_t'(v));
      rd_en[v]         = pop_v_i && pop_vc_oh_i[v];
      head_v_o[v]      = (count_q[v] != '0);
      head_flit_o[v]   = mem_q[v][rd_ptr_q[v]];
      head_dir_oh_o[v] = xy_route(head_flit_o[v], xy_id_x_i, xy_id_y_i);
      if (pop_vc_oh_i[v]) begin
        pop_id = vc_id_t'(v);
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      credit_v_o <= 1'b0;
    end else begin
      for (int v = 0; v < `FLOO_NUM_VC; v++) begin
        if (wr_en[v]) begin
          wr_ptr_q[v] <= next_ptr(wr_ptr_q[v]);
        end
        if (rd_en[v]) begin
          rd_ptr_q[v] <= next_ptr(rd_ptr_q[v]);
        end
        if (wr_en[v] && !rd_en[v]) begin
          count_q[v] <= count_q[v] + 1'b1;
        end else if (!wr_en[v] && rd_en[v]) begin
          count_q[v] <= count_q[v] - 1'b1;
        end
      end
      // one credit per popped flit, a cycle later
      credit_v_o <= pop_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    credit_id_o <= pop_id;
    if (data_v_i) begin
      mem_q[wr_vc][wr_ptr_q[wr_vc]] <= data_i;
    end
  end

  // upstream may only send while it holds a credit for that VC
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_v_i |-> (count_q[wr_vc] != credit_cnt_t'(`FLOO_VC_DEPTH)));

endmodule

/* floo_sa_global.sv */
// =========================================================================
// global switch allocator
// round-robin pick of one input port for a single output port
// =========================================================================

`timescale 1ns/1ns
`include "floo_cfg.svh"

module floo_sa_global (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  floo_vc_pkg::port_mask_t req_i,
  input  logic                    update_i,
  output floo_vc_pkg::port_mask_t grant_oh_o,
  output logic                    grant_v_o
);
  import floo_vc_pkg::*;

  localparam int idx_w = $clog2(`FLOO_NUM_PORTS);
  typedef logic [idx_w-1:0] port_idx_t;

  port_idx_t last_q;
  port_idx_t sel_idx;

  always_comb begin
    int cand;
    grant_oh_o = '0;
    grant_v_o  = 1'b0;
    sel_idx    = last_q;
    for (int i = 1; i <= `FLOO_NUM_PORTS; i++) begin
      cand = (int'(last_q) + i) % `FLOO_NUM_PORTS;
      if (!grant_v_o && req_i[cand]) begin
        grant_v_o        = 1'b1;
        grant_oh_o[cand] = 1'b1;
        sel_idx          = port_idx_t'(cand);
      end
    end
  end

  // move on only when the granted flit is sent
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= port_idx_t'(`FLOO_NUM_PORTS - 1);
    end else if (grant_v_o && update_i) begin
      last_q <= sel_idx;
    end
  end

endmodule

/* floo_sa_local.sv */
// =========================================================================
// local switch allocator
// round-robin pick of one requesting VC within an input port
// =========================================================================

`timescale 1ns/1ns
`include "floo_cfg.svh"

module floo_sa_local (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  floo_vc_pkg::vc_mask_t                       req_i,
  input  floo_vc_pkg::port_mask_t [`FLOO_NUM_VC-1:0]  head_dir_oh_i,
  input  logic                                        update_i,
  output floo_vc_pkg::vc_mask_t                       grant_vc_oh_o,
  output logic                                        grant_v_o,
  output floo_vc_pkg::port_mask_t                     dir_oh_o
);
  import floo_vc_pkg::*;

  vc_id_t last_q;
  vc_id_t sel_idx;

  // search starts right after the last VC served
  always_comb begin
    int cand;
    grant_vc_oh_o = '0;
    grant_v_o     = 1'b0;
    sel_idx       = last_q;
    for (int i = 1; i <= `FLOO_NUM_VC; i++) begin
      cand = (int'(last_q) + i) % `FLOO_NUM_VC;
      if (!grant_v_o && req_i[cand]) begin
        grant_v_o           = 1'b1;
        grant_vc_oh_o[cand] = 1'b1;
        sel_idx             = vc_id_t'(cand);
      end
    end
    dir_oh_o = grant_v_o ? head_dir_oh_i[sel_idx] : '0;
  end

  // pointer follows only popped choices
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_q <= vc_id_t'(`FLOO_NUM_VC - 1);
    end else if (update_i) begin
      last_q <= sel_idx;
    end
  end

  a_grant_oh: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(grant_vc_oh_o) && (!update_i || grant_v_o));

endmodule

/* floo_vc_pkg.sv */
// =========================================================================
// virtual channel package
// VC identifiers, credit counts and per-port masks
// =========================================================================

`include "floo_cfg.svh"

package floo_vc_pkg;

  typedef logic [$clog2(`FLOO_NUM_VC)-1:0] vc_id_t;

  // one bit per VC
  typedef logic [`FLOO_NUM_VC-1:0] vc_mask_t;

  // counts from 0 up to the full VC depth
  typedef logic [$clog2(`FLOO_VC_DEPTH+1)-1:0] credit_cnt_t;

  // one bit per router port
  typedef logic [`FLOO_NUM_PORTS-1:0] port_mask_t;

endpackage

/* floo_vc_router.sv */
// =========================================================================
// virtual channel mesh router
// XY routed five-port router with two-step switch allocation, per-output
// credit tracking and a register before switch traversal
// =========================================================================

`timescale 1ns/1ns
`include "floo_cfg.svh"

module floo_vc_router (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  floo_flit_pkg::coord_t                         xy_id_x_i,
  input  floo_flit_pkg::coord_t                         xy_id_y_i,
  input  floo_vc_pkg::port_mask_t                       data_v_i,
  input  floo_flit_pkg::flit_t [`FLOO_NUM_PORTS-1:0]    data_i,
  output floo_vc_pkg::port_mask_t                       credit_v_o,
  output floo_vc_pkg::vc_id_t [`FLOO_NUM_PORTS-1:0]     credit_id_o,
  output floo_vc_pkg::port_mask_t                       data_v_o,
  output floo_flit_pkg::flit_t [`FLOO_NUM_PORTS-1:0]    data_o,
  input  floo_vc_pkg::port_mask_t                       credit_v_i,
  input  floo_vc_pkg::vc_id_t [`FLOO_NUM_PORTS-1:0]     credit_id_i
);
  import floo_flit_pkg::*;
  import floo_vc_pkg::*;

  localparam int np = `FLOO_NUM_PORTS;
  localparam int nv = `FLOO_NUM_VC;

  // input space
  vc_mask_t [np-1:0]                head_v;
  flit_t [np-1:0][nv-1:0]           head_flit;
  port_mask_t [np-1:0][nv-1:0]      head_dir_oh;
  vc_mask_t [np-1:0]                local_req;
  vc_mask_t [np-1:0]                local_grant_vc_oh;
  port_mask_t [np-1:0]              local_dir_oh;
  port_mask_t                       pop_v;

  // output space
  port_mask_t [np-1:0]              global_req;
  port_mask_t [np-1:0]              global_grant_oh;
  port_mask_t                       global_v;
  port_mask_t                       vc_free;
  vc_id_t [np-1:0]                  vc_sel;
  flit_t [np-1:0]                   st_flit_d;

  // =========================================================================
  // per-port stages
  // =========================================================================
  for (genvar p = 0; p < np; p++) begin : gen_ports
    floo_input_port i_input_port (
      .clk_i, .arst_n_i,
      .data_v_i      (data_v_i[p]),
      .data_i        (data_i[p]),
      .xy_id_x_i, .xy_id_y_i,
      .pop_v_i       (pop_v[p]),
      .pop_vc_oh_i   (local_grant_vc_oh[p]),
      .head_v_o      (head_v[p]),
      .head_flit_o   (head_flit[p]),
      .head_dir_oh_o (head_dir_oh[p]),
      .credit_v_o    (credit_v_o[p]),
      .credit_id_o   (credit_id_o[p])
    );

    floo_sa_local i_sa_local (
      .clk_i, .arst_n_i,
      .req_i         (local_req[p]),
      .head_dir_oh_i (head_dir_oh[p]),
      .update_i      (pop_v[p]),
      .grant_vc_oh_o (local_grant_vc_oh[p]),
      .grant_v_o     (),
      .dir_oh_o      (local_dir_oh[p])
    );

    // a global grant always sends, so it also moves the pointer
    floo_sa_global i_sa_global (
      .clk_i, .arst_n_i,
      .req_i      (global_req[p]),
      .update_i   (global_v[p]),
      .grant_oh_o (global_grant_oh[p]),
      .grant_v_o  (global_v[p])
    );

    floo_credit_counter i_credit_counter (
      .clk_i, .arst_n_i,
      .credit_v_i  (credit_v_i[p]),
      .credit_id_i (credit_id_i[p]),
      .consume_v_i (global_v[p]),
      .vc_free_o   (vc_free[p]),
      .vc_sel_o    (vc_sel[p])
    );
  end

  // =========================================================================
  // input to output space mapping
  // =========================================================================
  always_comb begin
    for (int i = 0; i < np; i++) begin
      pop_v[i] = 1'b0;
      for (int v = 0; v < nv; v++) begin
        // only heads whose output has a free VC and is not the input itself
        local_req[i][v] = head_v[i][v]
                          && |(head_dir_oh[i][v] & vc_free & ~port_mask_t'(1 << i));
      end
      for (int o = 0; o < np; o++) begin
        global_req[o][i] = local_dir_oh[i][o];
        pop_v[i]         = pop_v[i] | global_grant_oh[o][i];
      end
    end
  end

  // granted head per output with the downstream VC written in
  always_comb begin
    for (int o = 0; o < np; o++) begin
      st_flit_d[o] = '0;
      for (int i = 0; i < np; i++) begin
        for (int v = 0; v < nv; v++) begin
          if (global_grant_oh[o][i] && local_grant_vc_oh[i][v]) begin
            st_flit_d[o] = head_flit[i][v];
          end
        end
      end
      st_flit_d[o][flit_vc_lsb +: flit_vc_w] = vc_sel[o];
    end
  end

  // =========================================================================
  // switch traversal register
  // =========================================================================
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_v_o <= '0;
    end else begin
      data_v_o <= global_v;
    end
  end

  always_ff @(posedge clk_i) begin
    data_o <= st_flit_d;
  end

  // every flit leaving pairs with one credit back to its input
  a_send_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $countones(data_v_o) == $countones(credit_v_o));

endmodule

/* floo_vc_router_tests.txt */
# name in_port in_vc dst_x dst_y payload(hex) expected_out_port
# ports 0 north, 1 east, 2 south, 3 west, 4 local; router at x=1 y=1
basic_n_to_e      0 0 2 1 1001 1
basic_n_to_s      0 1 1 3 1002 2
basic_n_to_w      0 0 0 2 1003 3
basic_e_to_w      1 0 0 0 1004 3
basic_e_to_l      1 1 1 1 1005 4
basic_s_to_n      2 0 1 0 1006 0
basic_s_to_e      2 1 3 3 1007 1
basic_w_to_e      3 0 2 0 1008 1
basic_w_to_l      3 1 1 1 1009 4
basic_l_to_n      4 0 1 0 100a 0
order_l_to_s_a    4 1 1 2 100b 2
order_l_to_s_b    4 1 1 3 100c 2
order_l_to_s_c    4 1 1 2 100d 2
hold_w0_east_a    3 0 3 1 2001 1
hold_w0_east_b    3 0 2 2 2002 1
hold_w1_east_a    3 1 2 3 2003 1
hold_w1_east_b    3 1 3 0 2004 1
hold_l0_east      4 0 2 1 2005 1
hold_n0_east      0 0 3 2 2006 1
hold_side_s_to_n  2 0 1 0 2007 0
hold_side_e_to_l  1 0 1 1 2008 4
hold_side_l_to_w  4 1 0 1 2009 3

/* tb_floo_vc_router.sv */
// ===========================================================================
// testbench for the virtual channel mesh router
// acts as upstream and downstream neighbor on all five ports and checks
// routing, ordering and credit flow against a table of flits
// ===========================================================================

`timescale 1ns/1ns
`include "floo_cfg.svh"

module tb_floo_vc_router;
  import floo_flit_pkg::*;
  import floo_vc_pkg::*;

  localparam int np = `FLOO_NUM_PORTS;
  localparam int nv = `FLOO_NUM_VC;
  localparam int depth = `FLOO_VC_DEPTH;
  localparam route_dir_e hold_dir = dir_east;

  logic                  clk_i;
  logic                  arst_n_i;
  coord_t                xy_id_x_i;
  coord_t                xy_id_y_i;
  port_mask_t            data_v_i;
  flit_t [np-1:0]        data_i;
  port_mask_t            credit_v_o;
  vc_id_t [np-1:0]       credit_id_o;
  port_mask_t            data_v_o;
  flit_t [np-1:0]        data_o;
  port_mask_t            credit_v_i;
  vc_id_t [np-1:0]       credit_id_i;

  // test table with one entry per data file line
  string  t_name[$];
  int     t_in_port[$];
  int     t_in_vc[$];
  int     t_dst_x[$];
  int     t_dst_y[$];
  int     t_payload[$];
  int     t_exp_port[$];
  bit     t_hold[$];
  bit     sent[$];
  bit     received[$];
  int     n_tests;

  // credit models and scoreboard
  int         up_cred[np][nv];
  int         ds_cred[np][nv];
  int         out_q[np][$];
  int         ret_due[np][$];
  vc_id_t     ret_vc[np][$];
  port_mask_t hold_mask;
  int         sent_total;
  int         recv_total;
  int         cycle;
  int         cycle_limit = 200;

  floo_vc_router i_dut (
    .clk_i, .arst_n_i,
    .xy_id_x_i, .xy_id_y_i,
    .data_v_i, .data_i,
    .credit_v_o, .credit_id_o,
    .data_v_o, .data_o,
    .credit_v_i, .credit_id_i
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ===========================================================================
  // helpers
  // ===========================================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error %s: expected flit %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_port(input string name, input route_dir_e exp, input route_dir_e act);
    if (act !== exp) begin
      abort_run($sformatf("Error %s: expected port %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_count(input string name, input credit_cnt_t exp, input credit_cnt_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error %s: expected count %0d, actual %0d", name, exp, act));
    end
  endtask

  // expected direction by x first then y from the router at (1,1)
  function automatic route_dir_e xy_dir(input int dx, input int dy);
    if (dx > 1) return dir_east;
    if (dx < 1) return dir_west;
    if (dy > 1) return dir_south;
    if (dy < 1) return dir_north;
    return dir_local;
  endfunction

  function automatic flit_t build_flit(input int t);
    flit_t f;
    f = '0;
    f[flit_dst_x_lsb +: `FLOO_COORD_W]     = coord_t'(t_dst_x[t]);
    f[flit_dst_y_lsb +: `FLOO_COORD_W]     = coord_t'(t_dst_y[t]);
    f[flit_vc_lsb +: flit_vc_w]            = vc_id_t'(t_in_vc[t]);
    f[flit_payload_lsb +: `FLOO_PAYLOAD_W] = t_payload[t][`FLOO_PAYLOAD_W-1:0];
    return f;
  endfunction

  function automatic flit_t clear_vc(input flit_t f);
    flit_t r;
    r = f;
    r[flit_vc_lsb +: flit_vc_w] = '0;
    return r;
  endfunction

  task automatic load_tests();
    int    fd;
    int    n;
    string line;
    string name;
    int    ip;
    int    iv;
    int    dx;
    int    dy;
    int    pl;
    int    ep;
    fd = $fopen("floo_vc_router_tests.txt", "r");
    if (fd == 0) abort_run("could not open the test data file");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %d %d %d %d %h %d", name, ip, iv, dx, dy, pl, ep);
      if (n != 7) abort_run($sformatf("malformed line in test data file: %s", line));
      check_port(name, xy_dir(dx, dy), route_dir_e'(ep));
      if (ip == ep) abort_run($sformatf("test %s would leave on its own input port", name));
      t_name.push_back(name);
      t_in_port.push_back(ip);
      t_in_vc.push_back(iv);
      t_dst_x.push_back(dx);
      t_dst_y.push_back(dy);
      t_payload.push_back(pl);
      t_exp_port.push_back(ep);
      t_hold.push_back(name.substr(0, 4) == "hold_");
      sent.push_back(1'b0);
      received.push_back(1'b0);
    end
    $fclose(fd);
    n_tests = t_name.size();
  endtask

  // starts 1 ns after a rising edge and returns at the same phase
  task automatic send_flit(input int t);
    int p;
    int v;
    p = t_in_port[t];
    v = t_in_vc[t];
    while (up_cred[p][v] == 0) begin
      @(posedge clk_i);
      #1;
    end
    data_v_i[p] = 1'b1;
    data_i[p]   = build_flit(t);
    up_cred[p][v]--;
    sent[t] = 1'b1;
    sent_total++;
    out_q[t_exp_port[t]].push_back(t);
    @(posedge clk_i);
    #1;
    data_v_i[p] = 1'b0;
  endtask

  task automatic receive_flit(input int o, input flit_t flit);
    int     t;
    int     pos;
    vc_id_t vc;
    t   = -1;
    pos = -1;
    for (int i = 0; i < n_tests; i++) begin
      if (sent[i] && !received[i]
          && t_payload[i][`FLOO_PAYLOAD_W-1:0] == flit[flit_payload_lsb +: `FLOO_PAYLOAD_W]) begin
        t = i;
      end
    end
    if (t < 0) abort_run($sformatf("output %0d delivered flit %h that is not outstanding", o, flit));
    check_port(t_name[t], route_dir_e'(t_exp_port[t]), route_dir_e'(o));
    for (int i = 0; i < out_q[o].size(); i++) begin
      if (out_q[o][i] == t) pos = i;
    end
    // an older flit of the same input VC must leave first
    for (int i = 0; i < pos; i++) begin
      if (t_in_port[out_q[o][i]] == t_in_port[t] && t_in_vc[out_q[o][i]] == t_in_vc[t]) begin
        abort_run($sformatf("test %s overtook test %s from the same input VC",
                            t_name[t], t_name[out_q[o][i]]));
      end
    end
    out_q[o].delete(pos);
    check_flit(t_name[t], clear_vc(build_flit(t)), clear_vc(flit));
    vc = flit[flit_vc_lsb +: flit_vc_w];
    if (ds_cred[o][vc] == 0) begin
      abort_run($sformatf("test %s sent on output %0d VC %0d without a credit", t_name[t], o, vc));
    end
    ds_cred[o][vc]--;
    received[t] = 1'b1;
    recv_total++;
    ret_due[o].push_back(cycle + 1 + int'($urandom % 4));
    ret_vc[o].push_back(vc);
  endtask

  task automatic wait_idle();
    int busy;
    busy = 1;
    while (busy != 0) begin
      @(posedge clk_i);
      busy = (recv_total != sent_total) ? 1 : 0;
      for (int o = 0; o < np; o++) begin
        if (ret_due[o].size() != 0) busy = 1;
      end
    end
    repeat (10) @(posedge clk_i);
    #1;
  endtask

  task automatic check_credits_home();
    for (int p = 0; p < np; p++) begin
      for (int v = 0; v < nv; v++) begin
        check_count($sformatf("upstream_credit_p%0d_vc%0d", p, v),
                    credit_cnt_t'(depth), credit_cnt_t'(up_cred[p][v]));
        check_count($sformatf("downstream_credit_p%0d_vc%0d", p, v),
                    credit_cnt_t'(depth), credit_cnt_t'(ds_cred[p][v]));
      end
    end
  endtask

  // side traffic of the hold phase has all arrived
  function automatic bit hold_phase_settled();
    for (int t = 0; t < n_tests; t++) begin
      if (t_hold[t] && t_exp_port[t] != int'(hold_dir) && !received[t]) return 1'b0;
    end
    return 1'b1;
  endfunction

  // ===========================================================================
  // monitors
  // ===========================================================================
  always @(posedge clk_i) begin
    cycle++;
    if (cycle > cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, the router stopped making progress", cycle));
    end
  end

  // outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (sent_total == 0 && (data_v_o !== '0 || credit_v_o !== '0)) begin
      abort_run("router output went active before any flit was sent");
    end
    for (int p = 0; p < np; p++) begin
      if (credit_v_o[p]) begin
        if (up_cred[p][credit_id_o[p]] >= depth) begin
          abort_run($sformatf("input %0d returned a credit for VC %0d with nothing outstanding",
                              p, credit_id_o[p]));
        end
        up_cred[p][credit_id_o[p]]++;
      end
      if (data_v_o[p]) receive_flit(p, data_o[p]);
    end
  end

  // downstream neighbor returns credits one per output per cycle
  always @(posedge clk_i) begin
    #1;
    credit_v_i = '0;
    for (int o = 0; o < np; o++) begin
      if (!hold_mask[o] && ret_due[o].size() != 0 && ret_due[o][0] <= cycle) begin
        credit_v_i[o]  = 1'b1;
        credit_id_i[o] = ret_vc[o][0];
        ds_cred[o][ret_vc[o][0]]++;
        void'(ret_due[o].pop_front());
        void'(ret_vc[o].pop_front());
      end
    end
  end

  // ===========================================================================
  // test sequence
  // ===========================================================================
  initial begin
    void'($urandom(32'hb53b_1212));
    arst_n_i    = 1'b0;
    xy_id_x_i   = coord_t'(1);
    xy_id_y_i   = coord_t'(1);
    data_v_i    = '0;
    data_i      = '0;
    credit_v_i  = '0;
    credit_id_i = '0;
    hold_mask   = '0;
    sent_total  = 0;
    recv_total  = 0;
    cycle       = 0;
    for (int p = 0; p < np; p++) begin
      for (int v = 0; v < nv; v++) begin
        up_cred[p][v] = depth;
        ds_cred[p][v] = depth;
      end
    end
    load_tests();
    cycle_limit = 50 * n_tests + 200;

    repeat (10) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    repeat (5) @(posedge clk_i);
    #1;

    // free running traffic
    for (int t = 0; t < n_tests; t++) begin
      if (!t_hold[t]) send_flit(t);
    end
    wait_idle();
    check_credits_home();

    // one output starved of credits while the others keep flowing
    hold_mask[hold_dir] = 1'b1;
    for (int t = 0; t < n_tests; t++) begin
      if (t_hold[t]) send_flit(t);
    end
    while (!hold_phase_settled()) @(posedge clk_i);
    repeat (20) @(posedge clk_i);
    for (int v = 0; v < nv; v++) begin
      check_count($sformatf("held_output_vc%0d_outstanding", v),
                  credit_cnt_t'(depth), credit_cnt_t'(depth - ds_cred[hold_dir][v]));
    end
    #1;
    hold_mask = '0;
    wait_idle();
    check_credits_home();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
